// File: include/commit_defines.svh
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// ----------------------------------------------------------------------
// machine sizing
// ----------------------------------------------------------------------
`define NWIN       8          // register windows per thread
`define TID_W      2          // thread id bits
`define TT_DAEX    8'h09      // data access exception

// op field, inst[31:30]
`define OP_FMT2    2'b00
`define OP_CALL    2'b01
`define OP_FMT3    2'b10
`define OP_LDST    2'b11

// op2 field, format 2
`define OP2_BICC   3'b010
`define OP2_SETHI  3'b100

// op3 field, format 3 arith / control
`define OP3_WRY    6'h30
`define OP3_WRPSR  6'h31
`define OP3_WRWIM  6'h32
`define OP3_WRTBR  6'h33
`define OP3_JMPL   6'h38
`define OP3_RETT   6'h39
`define OP3_TICC   6'h3a
`define OP3_FLUSH  6'h3b

// op3 field, loads (alternate space forms have bit 4 set)
`define OP3_LD     6'h00
`define OP3_LDUB   6'h01
`define OP3_LDUH   6'h02
`define OP3_LDD    6'h03
`define OP3_LDSB   6'h09
`define OP3_LDSH   6'h0a
`define OP3_LDA    6'h10
`define OP3_LDUBA  6'h11
`define OP3_LDUHA  6'h12
`define OP3_LDDA   6'h13
`define OP3_LDSBA  6'h19
`define OP3_LDSHA  6'h1a

// psr after reset, supervisor with traps off
`define RESET_S    1'b1
`define RESET_ET   1'b0
`define RESET_CWP  0

`endif

// File: source/commit_pkg.sv
`include "commit_defines.svh"

package commit_pkg;

	// ------------------------------------------------------------------
	// datapath widths
	// ------------------------------------------------------------------
	typedef logic [31:0]                 word_t;    // alu / load word
	typedef logic [63:0]                 dword_t;   // ldd pair from memory
	typedef logic [29:0]                 waddr_t;   // pc / npc, word granular
	typedef logic [$clog2(`NWIN)-1:0]    cwp_t;
	typedef logic [`TID_W-1:0]           tid_t;
	typedef logic [4:0]                  rd_t;      // architectural reg number
	typedef logic [`TID_W+8-1:0]         regaddr_t; // {tid, window index}
	typedef logic [7:0]                  tt_t;
	typedef logic [3:0]                  bmask_t;   // byte 0 is the msb

	// source of the port 1 write data
	typedef enum logic [1:0] {
		WB_NONE,     // nothing on port 1
		WB_ALU,      // ex_res
		WB_LINK,     // pc of this instr, call / jmpl
		WB_LDD_HI    // upper word of ldd
	} wb_kind_e;

endpackage

// File: source/commit_ifs.sv
`timescale 1ns/1ps

// decoded instruction class, fanned out to trap, write-back and pc logic
interface decode_if;
	logic                 wnpc;      // npc taken from alu
	logic                 rett;
	logic                 wrpsr;
	commit_pkg::wb_kind_e wb1_kind;
	logic                 wb2_load;  // port 2 gets aligned load data
	commit_pkg::rd_t      rd;        // 15 for call, else inst rd

	modport dec (output wnpc, rett, wrpsr, wb1_kind, wb2_load, rd);
	modport user (input wnpc, rett, wrpsr, wb1_kind, wb2_load, rd);
endinterface

// trap decision and the psr it leaves behind
interface trap_if;
	logic              trap;
	commit_pkg::tt_t   tt;
	commit_pkg::cwp_t  next_cwp;
	logic              next_et;
	logic              next_s;
	logic              next_ps;

	modport src (
		output trap, tt,
		output next_cwp, next_et, next_s, next_ps
	);
	modport user (
		input trap, tt,
		input next_cwp, next_et, next_s, next_ps
	);
endinterface

// File: source/instr_decode.sv
`timescale 1ns/1ps
`include "commit_defines.svh"

module instr_decode (
	input  commit_pkg::word_t inst,
	input  logic              branch_true,
	decode_if.dec             dec
);
	logic [1:0]      op;
	logic [2:0]      op2;
	logic [5:0]      op3;
	commit_pkg::rd_t rd;

	assign op  = inst[31:30];
	assign op2 = inst[24:22];
	assign op3 = inst[24:19];
	assign rd  = inst[29:25];

	always_comb begin
		dec.wnpc     = 1'b0;
		dec.rett     = 1'b0;
		dec.wrpsr    = 1'b0;
		dec.wb1_kind = commit_pkg::WB_NONE;
		dec.wb2_load = 1'b0;
		dec.rd       = rd;
		case (op)
		`OP_CALL: begin
			dec.wnpc     = 1'b1;
			dec.wb1_kind = commit_pkg::WB_LINK;
			dec.rd       = 5'd15;                  // %o7
		end
		`OP_FMT2: begin
			if (op2 == `OP2_SETHI)
				dec.wb1_kind = commit_pkg::WB_ALU;
			else if (op2 == `OP2_BICC)
				dec.wnpc = branch_true;           // only taken branches redirect
		end
		`OP_FMT3: begin
			case (op3)
			`OP3_JMPL: begin
				dec.wnpc     = 1'b1;
				dec.wb1_kind = commit_pkg::WB_LINK;
			end
			`OP3_RETT: begin
				dec.wnpc = 1'b1;
				dec.rett = 1'b1;
			end
			`OP3_WRPSR: dec.wrpsr = 1'b1;
			`OP3_TICC, `OP3_WRY, `OP3_WRWIM, `OP3_WRTBR, `OP3_FLUSH: ;  // no rf write here
			default: dec.wb1_kind = commit_pkg::WB_ALU;                   // plain alu op
			endcase
		end
		`OP_LDST: begin
			case (op3)
			`OP3_LD, `OP3_LDUB, `OP3_LDUH, `OP3_LDSB, `OP3_LDSH,
			`OP3_LDA, `OP3_LDUBA, `OP3_LDUHA, `OP3_LDSBA, `OP3_LDSHA:
				dec.wb2_load = 1'b1;
			`OP3_LDD, `OP3_LDDA: begin
				dec.wb2_load = 1'b1;                   // low word to rd
				dec.wb1_kind = commit_pkg::WB_LDD_HI;  // high word to rd|1
			end
			default: ;                                 // stores, atomics
			endcase
		end
		default: ;
		endcase
	end

endmodule

// File: source/trap_psr_unit.sv
`timescale 1ns/1ps
`include "commit_defines.svh"

module trap_psr_unit (
	input  logic              in_valid,
	input  logic              annul,
	input  logic              precise_trap,
	input  logic              irq_trap,
	input  logic              dmmu_exception,
	input  commit_pkg::tt_t   precise_tt,
	input  commit_pkg::tt_t   irq_tt,
	input  commit_pkg::cwp_t  cwp,
	input  logic              s,
	input  logic              ps,
	input  logic              et,
	input  commit_pkg::word_t ex_res,
	decode_if.user            dec,
	trap_if.src               trp
);
	logic live;  // instruction really retires

	assign live     = in_valid & ~annul;
	assign trp.trap = live & (precise_trap | irq_trap | dmmu_exception);

	// ------------------------------------------------------------------
	// trap type, dmmu beats precise beats interrupt
	// ------------------------------------------------------------------
	always_comb begin
		if (dmmu_exception)
			trp.tt = `TT_DAEX;
		else if (precise_trap)
			trp.tt = precise_tt;
		else
			trp.tt = irq_tt;
	end

	// ------------------------------------------------------------------
	// next psr fields
	// ------------------------------------------------------------------
	always_comb begin
		trp.next_cwp = cwp;   // default hold
		trp.next_et  = et;
		trp.next_s   = s;
		trp.next_ps  = ps;
		if (trp.trap) begin
			trp.next_cwp = (cwp == '0) ? commit_pkg::cwp_t'(`NWIN - 1) : cwp - 1'b1;
			trp.next_et  = 1'b0;
			trp.next_ps  = s;   // remember old mode
			trp.next_s   = 1'b1;
		end else if (live && dec.rett) begin
			trp.next_et = 1'b1;
			trp.next_s  = ps;
		end else if (live && dec.wrpsr) begin
			trp.next_s   = ex_res[7];
			trp.next_ps  = ex_res[6];
			trp.next_et  = ex_res[5];
			trp.next_cwp = ex_res[2:0];
		end
	end

endmodule

// File: source/load_aligner.sv
`timescale 1ns/1ps

module load_aligner (
	input  commit_pkg::word_t  word,
	input  commit_pkg::bmask_t byte_mask,
	input  logic               signext,
	output commit_pkg::word_t  aligned
);
	logic [7:0]  sel_b;  // picked byte
	logic [15:0] sel_h;  // picked halfword

	always_comb begin
		sel_b = word[7:0];
		sel_h = word[15:0];
		case (byte_mask)
		4'b0001: sel_b = word[31:24];   // big endian, byte 0 on top
		4'b0010: sel_b = word[23:16];
		4'b0100: sel_b = word[15:8];
		4'b0011: sel_h = word[31:16];
		default: ;
		endcase
		case (byte_mask)
		4'b0001, 4'b0010, 4'b0100, 4'b1000: aligned = {{24{signext & sel_b[7]}}, sel_b};
		4'b0011, 4'b1100:                   aligned = {{16{signext & sel_h[15]}}, sel_h};
		default:                            aligned = word;   // full word
		endcase
	end

	always_comb begin
		assert ($isunknown(byte_mask) || byte_mask inside {4'b0001, 4'b0010, 4'b0100,
			4'b1000, 4'b0011, 4'b1100, 4'b1111})
			else $error("illegal load byte mask %b", byte_mask);
	end

endmodule

// File: source/regwrite_gen.sv
`timescale 1ns/1ps
`include "commit_defines.svh"

module regwrite_gen (
	input  logic                 in_valid,
	input  logic                 annul,
	input  commit_pkg::tid_t     tid,
	input  commit_pkg::waddr_t   pc,
	input  commit_pkg::waddr_t   npc,
	input  commit_pkg::word_t    ex_res,
	input  commit_pkg::dword_t   mem_res,
	input  commit_pkg::bmask_t   byte_mask,
	input  logic                 signext,
	decode_if.user               dec,
	trap_if.user                 trp,
	output commit_pkg::regaddr_t rf1_addr,
	output commit_pkg::regaddr_t rf2_addr,
	output commit_pkg::word_t    rf1_data,
	output commit_pkg::word_t    rf2_data,
	output logic                 rf1_we,
	output logic                 rf2_we
);
	commit_pkg::word_t ld_word;   // aligned low word of mem_res
	commit_pkg::rd_t   rd1;
	commit_pkg::rd_t   rd2;
	logic              wr1;       // port 1 has something to write
	logic              wr2;
	logic              live;

	// globals sit below the windows, windows overlap by 8 regs
	function automatic commit_pkg::regaddr_t win_addr(commit_pkg::tid_t t,
		commit_pkg::cwp_t c, commit_pkg::rd_t r);
		logic [7:0]  idx;
		logic [10:0] lin;
		lin = {c, 4'b0000} + 11'(r) - 11'd8;
		if (r < 5'd8)
			idx = {3'b000, r};
		else
			idx = 8'd8 + 8'(lin % (`NWIN * 16));
		return {t, idx};
	endfunction

	load_aligner load_aligner_i (
		.word      (mem_res[31:0]),
		.byte_mask (byte_mask),
		.signext   (signext),
		.aligned   (ld_word)
	);

	assign live = in_valid & ~annul;

	// ------------------------------------------------------------------
	// register number and data per port, trap overrides both
	// ------------------------------------------------------------------
	always_comb begin
		rd1      = dec.rd;
		rd2      = dec.rd;
		rf1_data = ex_res;
		rf2_data = ld_word;
		wr1      = dec.wb1_kind != commit_pkg::WB_NONE;
		wr2      = dec.wb2_load;
		case (dec.wb1_kind)
		commit_pkg::WB_LINK:   rf1_data = {pc, 2'b00};
		commit_pkg::WB_LDD_HI: begin
			rd1      = {dec.rd[4:1], 1'b1};   // odd half of the pair
			rf1_data = mem_res[63:32];
		end
		default: ;
		endcase
		if (trp.trap) begin
			rd1      = 5'd17;                 // %l1 <- pc
			rf1_data = {pc, 2'b00};
			rd2      = 5'd18;                 // %l2 <- npc
			rf2_data = {npc, 2'b00};
		end
	end

	// new cwp so trap saves land in the trap window
	assign rf1_addr = win_addr(tid, trp.next_cwp, rd1);
	assign rf2_addr = win_addr(tid, trp.next_cwp, rd2);

	// r0 is never written except by a trap save
	assign rf1_we = live & (trp.trap | (wr1 & (rd1 != '0)));
	assign rf2_we = live & (trp.trap | (wr2 & (rd2 != '0)));

	always_comb begin
		assert (!(rf1_we === 1'b1 && rf2_we === 1'b1 && rf1_addr == rf2_addr))
			else $error("both rf ports write %h", rf1_addr);
	end

endmodule

// File: source/commit_reg.sv
`timescale 1ns/1ps
`include "commit_defines.svh"

module commit_reg (
	input  logic                 gclk,
	input  logic                 rst,
	input  logic                 in_valid,
	input  logic                 annul,
	input  commit_pkg::waddr_t   npc,
	input  commit_pkg::word_t    ex_res,
	input  commit_pkg::regaddr_t wr1_addr,
	input  commit_pkg::regaddr_t wr2_addr,
	input  commit_pkg::word_t    wr1_data,
	input  commit_pkg::word_t    wr2_data,
	input  logic                 wr1_we,
	input  logic                 wr2_we,
	decode_if.user               dec,
	trap_if.user                 trp,
	output commit_pkg::waddr_t   pc_out,
	output commit_pkg::waddr_t   npc_out,
	output logic                 pc_we,
	output logic                 npc_we,
	output logic                 trap_out,
	output commit_pkg::tt_t      tt_out,
	output commit_pkg::cwp_t     cwp_out,
	output logic                 s_out,
	output logic                 ps_out,
	output logic                 et_out,
	output commit_pkg::regaddr_t rf1_addr,
	output commit_pkg::regaddr_t rf2_addr,
	output commit_pkg::word_t    rf1_data,
	output commit_pkg::word_t    rf2_data,
	output logic                 rf1_we,
	output logic                 rf2_we
);
	commit_pkg::waddr_t npc_nx;

	// redirect from alu, else fall through one word
	assign npc_nx = (dec.wnpc && !annul) ? ex_res[31:2] : npc + 1'b1;

	// ------------------------------------------------------------------
	// control state
	// ------------------------------------------------------------------
	always_ff @(posedge gclk) begin
		if (rst) begin
			pc_out   <= '0;
			npc_out  <= 30'd1;
			pc_we    <= 1'b0;
			npc_we   <= 1'b0;
			trap_out <= 1'b0;
			tt_out   <= '0;
			cwp_out  <= commit_pkg::cwp_t'(`RESET_CWP);
			s_out    <= `RESET_S;
			ps_out   <= 1'b0;
			et_out   <= `RESET_ET;
			rf1_we   <= 1'b0;
			rf2_we   <= 1'b0;
		end else begin
			pc_out   <= npc;       // pc <- npc
			npc_out  <= npc_nx;
			pc_we    <= in_valid;
			npc_we   <= in_valid;
			trap_out <= trp.trap;
			tt_out   <= trp.tt;
			cwp_out  <= trp.next_cwp;
			s_out    <= trp.next_s;
			ps_out   <= trp.next_ps;
			et_out   <= trp.next_et;
			rf1_we   <= wr1_we;
			rf2_we   <= wr2_we;
		end
	end

	// write port payload, qualified by the enables above
	always_ff @(posedge gclk) begin
		rf1_addr <= wr1_addr;
		rf2_addr <= wr2_addr;
		rf1_data <= wr1_data;
		rf2_data <= wr2_data;
	end

	// trap saves of pc and npc land in adjacent locals of the new window
	a_trap_save_pair: assert property (@(posedge gclk) disable iff (rst)
		trap_out |-> (rf2_addr == rf1_addr + 1'b1))
		else $error("trap saves not in adjacent registers, %h and %h", rf1_addr, rf2_addr);

endmodule

// File: source/commit_top.sv
`timescale 1ns/1ps

module commit_top (
	input  logic                 gclk,
	input  logic                 rst,
	input  logic                 in_valid,
	input  logic                 annul,
	input  logic                 branch_true,
	input  logic                 precise_trap,
	input  logic                 irq_trap,
	input  logic                 dmmu_exception,
	input  logic                 signext,
	input  commit_pkg::tid_t     tid,
	input  commit_pkg::word_t    inst,
	input  commit_pkg::word_t    ex_res,
	input  commit_pkg::dword_t   mem_res,
	input  commit_pkg::waddr_t   pc,
	input  commit_pkg::waddr_t   npc,
	input  commit_pkg::cwp_t     cwp,
	input  logic                 s,
	input  logic                 ps,
	input  logic                 et,
	input  commit_pkg::bmask_t   byte_mask,
	input  commit_pkg::tt_t      precise_tt,
	input  commit_pkg::tt_t      irq_tt,
	output commit_pkg::waddr_t   pc_out,
	output commit_pkg::waddr_t   npc_out,
	output logic                 pc_we,
	output logic                 npc_we,
	output logic                 trap_out,
	output logic                 s_out,
	output logic                 ps_out,
	output logic                 et_out,
	output commit_pkg::cwp_t     cwp_out,
	output commit_pkg::tt_t      tt_out,
	output commit_pkg::regaddr_t rf1_addr,
	output commit_pkg::regaddr_t rf2_addr,
	output commit_pkg::word_t    rf1_data,
	output commit_pkg::word_t    rf2_data,
	output logic                 rf1_we,
	output logic                 rf2_we
);
	decode_if dec_if ();
	trap_if   trp_if ();

	// unregistered write ports, into commit_reg
	commit_pkg::regaddr_t wr1_addr;
	commit_pkg::regaddr_t wr2_addr;
	commit_pkg::word_t    wr1_data;
	commit_pkg::word_t    wr2_data;
	logic                 wr1_we;
	logic                 wr2_we;

	instr_decode instr_decode_i (
		.inst        (inst),
		.branch_true (branch_true),
		.dec         (dec_if)
	);

	trap_psr_unit trap_psr_unit_i (
		.in_valid       (in_valid),
		.annul          (annul),
		.precise_trap   (precise_trap),
		.irq_trap       (irq_trap),
		.dmmu_exception (dmmu_exception),
		.precise_tt     (precise_tt),
		.irq_tt         (irq_tt),
		.cwp            (cwp),
		.s              (s),
		.ps             (ps),
		.et             (et),
		.ex_res         (ex_res),
		.dec            (dec_if),
		.trp            (trp_if)
	);

	regwrite_gen regwrite_gen_i (
		.in_valid  (in_valid),
		.annul     (annul),
		.tid       (tid),
		.pc        (pc),
		.npc       (npc),
		.ex_res    (ex_res),
		.mem_res   (mem_res),
		.byte_mask (byte_mask),
		.signext   (signext),
		.dec       (dec_if),
		.trp       (trp_if),
		.rf1_addr  (wr1_addr),
		.rf2_addr  (wr2_addr),
		.rf1_data  (wr1_data),
		.rf2_data  (wr2_data),
		.rf1_we    (wr1_we),
		.rf2_we    (wr2_we)
	);

	commit_reg commit_reg_i (
		.gclk     (gclk),
		.rst      (rst),
		.in_valid (in_valid),
		.annul    (annul),
		.npc      (npc),
		.ex_res   (ex_res),
		.wr1_addr (wr1_addr),
		.wr2_addr (wr2_addr),
		.wr1_data (wr1_data),
		.wr2_data (wr2_data),
		.wr1_we   (wr1_we),
		.wr2_we   (wr2_we),
		.dec      (dec_if),
		.trp      (trp_if),
		.pc_out   (pc_out),
		.npc_out  (npc_out),
		.pc_we    (pc_we),
		.npc_we   (npc_we),
		.trap_out (trap_out),
		.tt_out   (tt_out),
		.cwp_out  (cwp_out),
		.s_out    (s_out),
		.ps_out   (ps_out),
		.et_out   (et_out),
		.rf1_addr (rf1_addr),
		.rf2_addr (rf2_addr),
		.rf1_data (rf1_data),
		.rf2_data (rf2_data),
		.rf1_we   (rf1_we),
		.rf2_we   (rf2_we)
	);

endmodule

// File: tb/commit_tb.sv
`timescale 1ns/1ps

module commit_tb;
	localparam int EDGE_LIMIT = 40;   // 1 ns polls before an edge counts as lost

	// ------------------------------------------------------------------
	// dut ports
	// ------------------------------------------------------------------
	logic                 gclk;
	logic                 rst;
	logic                 in_valid;
	logic                 annul;
	logic                 branch_true;
	logic                 precise_trap;
	logic                 irq_trap;
	logic                 dmmu_exception;
	logic                 signext;
	commit_pkg::tid_t     tid;
	commit_pkg::word_t    inst;
	commit_pkg::word_t    ex_res;
	commit_pkg::dword_t   mem_res;
	commit_pkg::waddr_t   pc;
	commit_pkg::waddr_t   npc;
	commit_pkg::cwp_t     cwp;
	logic                 s;
	logic                 ps;
	logic                 et;
	commit_pkg::bmask_t   byte_mask;
	commit_pkg::tt_t      precise_tt;
	commit_pkg::tt_t      irq_tt;
	commit_pkg::waddr_t   pc_out;
	commit_pkg::waddr_t   npc_out;
	logic                 pc_we;
	logic                 npc_we;
	logic                 trap_out;
	logic                 s_out;
	logic                 ps_out;
	logic                 et_out;
	commit_pkg::cwp_t     cwp_out;
	commit_pkg::tt_t      tt_out;
	commit_pkg::regaddr_t rf1_addr;
	commit_pkg::regaddr_t rf2_addr;
	commit_pkg::word_t    rf1_data;
	commit_pkg::word_t    rf2_data;
	logic                 rf1_we;
	logic                 rf2_we;

	// one golden line, f_ is stimulus and x_ is expected
	string                f_name;
	logic [6:0]           f_ctl;    // valid annul br prec irq dmmu sext
	commit_pkg::tid_t     f_tid;
	commit_pkg::word_t    f_inst;
	commit_pkg::word_t    f_ex;
	commit_pkg::dword_t   f_mem;
	commit_pkg::waddr_t   f_pc;
	commit_pkg::waddr_t   f_npc;
	logic [5:0]           f_psr;    // s ps et cwp
	commit_pkg::bmask_t   f_mask;
	commit_pkg::tt_t      f_ptt;
	commit_pkg::tt_t      f_itt;
	commit_pkg::waddr_t   x_pc;
	commit_pkg::waddr_t   x_npc;
	logic [4:0]           x_flg;    // pc_we npc_we trap we1 we2
	logic [5:0]           x_psr;
	commit_pkg::tt_t      x_tt;
	commit_pkg::regaddr_t x_a1;
	commit_pkg::regaddr_t x_a2;
	commit_pkg::word_t    x_d1;
	commit_pkg::word_t    x_d2;

	int n_tests;
	int n_failed;
	int n_miss;      // mismatches in the running test
	bit late;        // some clock wait ran out

	commit_top commit_top_i (.*);

	initial begin
		gclk = 1'b0;
		forever #10 gclk = ~gclk;   // 20 ns period
	end

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	// polls at half-ns offsets, so never on an edge
	task automatic wait_rise(input string what, output bit timed_out);
		logic prev;
		int   polls;
		bit   seen;
		prev  = gclk;
		polls = 0;
		seen  = 1'b0;
		while (!seen && polls < EDGE_LIMIT) begin
			#1;
			polls++;
			if (prev === 1'b0 && gclk === 1'b1)
				seen = 1'b1;
			prev = gclk;
		end
		timed_out = !seen;
		if (!seen)
			$display("no rising gclk edge within %0d ns while %s", EDGE_LIMIT, what);
	endtask

	task automatic set_idle_inputs();
		in_valid       = 1'b0;
		annul          = 1'b0;
		branch_true    = 1'b0;
		precise_trap   = 1'b0;
		irq_trap       = 1'b0;
		dmmu_exception = 1'b0;
		signext        = 1'b0;
		tid            = '0;
		inst           = '0;
		ex_res         = '0;
		mem_res        = '0;
		pc             = '0;
		npc            = '0;
		cwp            = '0;
		s              = 1'b0;
		ps             = 1'b0;
		et             = 1'b0;
		byte_mask      = 4'b1111;   // full word, legal for the aligner
		precise_tt     = '0;
		irq_tt         = '0;
	endtask

	task automatic apply_stimulus();
		in_valid       = f_ctl[6];
		annul          = f_ctl[5];
		branch_true    = f_ctl[4];
		precise_trap   = f_ctl[3];
		irq_trap       = f_ctl[2];
		dmmu_exception = f_ctl[1];
		signext        = f_ctl[0];
		tid            = f_tid;
		inst           = f_inst;
		ex_res         = f_ex;
		mem_res        = f_mem;
		pc             = f_pc;
		npc            = f_npc;
		s              = f_psr[5];
		ps             = f_psr[4];
		et             = f_psr[3];
		cwp            = f_psr[2:0];
		byte_mask      = f_mask;
		precise_tt     = f_ptt;
		irq_tt         = f_itt;
	endtask

	task automatic compare_field(input string field, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s %s expected %h actual %h", f_name, field, exp, act);
			n_miss++;
		end
	endtask

	// pc 0, npc 1, supervisor with traps off, nothing enabled
	task automatic verify_reset();
		compare_field("pc_out", 32'h0, 32'(pc_out));
		compare_field("npc_out", 32'h1, 32'(npc_out));
		compare_field("pc_we", 32'h0, 32'(pc_we));
		compare_field("npc_we", 32'h0, 32'(npc_we));
		compare_field("trap_out", 32'h0, 32'(trap_out));
		compare_field("rf1_we", 32'h0, 32'(rf1_we));
		compare_field("rf2_we", 32'h0, 32'(rf2_we));
		compare_field("s_out", 32'h1, 32'(s_out));
		compare_field("ps_out", 32'h0, 32'(ps_out));
		compare_field("et_out", 32'h0, 32'(et_out));
		compare_field("cwp_out", 32'h0, 32'(cwp_out));
		compare_field("tt_out", 32'h0, 32'(tt_out));
	endtask

	task automatic check_outputs();
		compare_field("pc_out", 32'(x_pc), 32'(pc_out));
		compare_field("npc_out", 32'(x_npc), 32'(npc_out));
		compare_field("pc_we", 32'(x_flg[4]), 32'(pc_we));
		compare_field("npc_we", 32'(x_flg[3]), 32'(npc_we));
		compare_field("trap_out", 32'(x_flg[2]), 32'(trap_out));
		compare_field("rf1_we", 32'(x_flg[1]), 32'(rf1_we));
		compare_field("rf2_we", 32'(x_flg[0]), 32'(rf2_we));
		compare_field("s_out", 32'(x_psr[5]), 32'(s_out));
		compare_field("ps_out", 32'(x_psr[4]), 32'(ps_out));
		compare_field("et_out", 32'(x_psr[3]), 32'(et_out));
		compare_field("cwp_out", 32'(x_psr[2:0]), 32'(cwp_out));
		compare_field("tt_out", 32'(x_tt), 32'(tt_out));
		if (x_flg[1]) begin   // addr and data only mean something when enabled
			compare_field("rf1_addr", 32'(x_a1), 32'(rf1_addr));
			compare_field("rf1_data", x_d1, rf1_data);
		end
		if (x_flg[0]) begin
			compare_field("rf2_addr", 32'(x_a2), 32'(rf2_addr));
			compare_field("rf2_data", x_d2, rf2_data);
		end
	endtask

	task automatic report_test();
		n_tests++;
		if (n_miss == 0) begin
			$display("test %s: ok", f_name);
		end else begin
			n_failed++;
			$display("test %s: %0d mismatches", f_name, n_miss);
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		int    fd;
		int    cnt;
		string line;
		n_tests  = 0;
		n_failed = 0;
		n_miss   = 0;
		late     = 1'b0;
		rst      = 1'b1;
		set_idle_inputs();
		fd = $fopen("tb/commit_golden.txt", "r");
		if (fd == 0)
			$display("could not open tb/commit_golden.txt");
		#0.5;                                  // tb runs on x.5 ns, edges on x0
		repeat (3) begin
			if (!late)
				wait_rise("reset is held", late);
		end
		if (!late) begin
			#1;
			f_name = "reset";
			n_miss = 0;
			verify_reset();
			report_test();
			#1;
			rst = 1'b0;                        // first test goes in with it
		end
		while (!late && fd != 0 && $fgets(line, fd) > 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;                      // blank or column notes
			n_miss = 0;
			cnt = $sscanf(line,
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f_name, f_ctl, f_tid, f_inst, f_ex, f_mem, f_pc, f_npc, f_psr,
				f_mask, f_ptt, f_itt, x_pc, x_npc, x_flg, x_psr, x_tt,
				x_a1, x_a2, x_d1, x_d2);
			if (cnt != 21) begin
				$display("golden line has %0d of 21 fields: %s", cnt, line);
				n_miss = 1;
				report_test();
				continue;
			end
			apply_stimulus();                  // edge + 2.5 ns
			wait_rise({"running ", f_name}, late);
			if (!late) begin
				#1;                            // registered outputs settled
				check_outputs();
				report_test();
				#1;
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_failed, n_failed);
		if (late || fd == 0 || n_failed != 0 || n_tests < 2)
			$display("Checks failed");
		else
			$display("All checks passed");
		$finish;
	end

endmodule

// File: tb/commit_golden.txt
# name ctl tid inst ex_res mem_res pc npc psr mask ptt itt / pc npc flg psr tt a1 a2 d1 d2
# ctl={valid,annul,br,prec,irq,dmmu,sext} psr={s,ps,et,cwp} flg={pc_we,npc_we,trap,we1,we2}
alu_c3        40 1 a0000000 12345678 0 100 101 2b f 00 00 101 102 1a 2b 00 140 000 12345678 0
alu_r0        40 0 80000000 deadbeef 0 100 101 28 f 00 00 101 102 18 28 00 000 000 0 0
alu_global    40 2 8a100000 0000beef 0 100 101 2d f 00 00 101 102 1a 2d 00 205 000 0000beef 0
alu_wrap      40 3 be000000 0badf00d 0 100 101 0f f 00 00 101 102 1a 0f 00 30f 000 0badf00d 0
sethi         40 0 13000000 ab000000 0 100 101 2a f 00 00 101 102 1a 2a 00 029 000 ab000000 0
call          40 0 40000010 00001000 0 200 201 29 f 00 00 201 400 1a 29 00 01f 000 00000800 0
jmpl          40 0 9fc00000 00002000 0 300 301 2c f 00 00 301 800 1a 2c 00 04f 000 00000c00 0
jmpl_r0       40 0 81c00000 00003000 0 300 301 28 f 00 00 301 c00 18 28 00 000 000 0 0
bicc_taken    50 0 10800004 00001100 0 400 401 28 f 00 00 401 440 18 28 00 000 000 0 0
bicc_ntaken   40 0 10800004 00001100 0 400 401 28 f 00 00 401 402 18 28 00 000 000 0 0
ldsb_b0       41 0 d0480000 0 81c2f384 500 501 28 1 00 00 501 502 19 28 00 000 008 0 ffffff81
ldsb_b1       41 0 d0480000 0 81c2f384 500 501 28 2 00 00 501 502 19 28 00 000 008 0 ffffffc2
ldsb_b2       41 0 d0480000 0 81c2f384 500 501 28 4 00 00 501 502 19 28 00 000 008 0 fffffff3
ldsb_b3       41 0 d0480000 0 81c2f384 500 501 28 8 00 00 501 502 19 28 00 000 008 0 ffffff84
ldsh_hi       41 0 d0500000 0 81c2f384 500 501 28 3 00 00 501 502 19 28 00 000 008 0 ffff81c2
ldsh_lo       41 0 d0500000 0 81c2f384 500 501 28 c 00 00 501 502 19 28 00 000 008 0 fffff384
ldub_b1       40 0 d0080000 0 81c2f384 500 501 28 2 00 00 501 502 19 28 00 000 008 0 000000c2
lduh_hi       40 0 d0100000 0 81c2f384 500 501 28 3 00 00 501 502 19 28 00 000 008 0 000081c2
ldd           40 2 d0180000 0 1122334455667788 500 501 28 f 00 00 501 502 1b 28 00 209 208 11223344 55667788
trap_prec     48 0 a0000000 0 0 600 601 18 f 05 1a 601 602 1f 27 05 081 082 00001800 00001804
trap_irq      44 1 a0000000 0 0 700 701 2b f 05 1a 701 702 1f 32 1a 131 132 00001c00 00001c04
trap_dmmu     42 0 a0000000 0 0 800 801 09 f 05 1a 801 802 1f 20 09 011 012 00002000 00002004
trap_prec_irq 4c 3 a0000000 0 0 900 901 3d f 05 1a 901 902 1f 34 05 351 352 00002400 00002404
trap_all      4e 0 a0000000 0 0 a00 a01 1f f 05 1a a01 a02 1f 26 09 071 072 00002800 00002804
rett          40 0 81c80000 00004000 0 b00 b01 12 f 00 00 b01 1000 18 3a 00 000 000 0 0
wrpsr         40 0 81880000 000000a6 0 c00 c01 11 f 00 00 c01 c02 18 2e 00 000 000 0 0
annul_trap    6a 0 9fc00000 00005000 0 d00 d01 2b f 05 1a d01 d02 18 2b 09 000 000 0 0
invalid       08 0 a0000000 11111111 0 e00 e01 2b f 05 1a e01 e02 00 2b 05 000 000 0 0

// File: project.f
+incdir+include
source/commit_pkg.sv
source/commit_ifs.sv
source/instr_decode.sv
source/trap_psr_unit.sv
source/load_aligner.sv
source/regwrite_gen.sv
source/commit_reg.sv
source/commit_top.sv
tb/commit_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the commit stage testbench with verilator, runs it into sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module commit_tb \
	&& ./obj_dir/Vcommit_tb | tee sim.log \
	&& grep -qx "All checks passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
